// ==== Makefile ====
# Verilator flow for the 8x8 inverse DCT engine

TOP = idctTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/blockStore.sv ====
// intermediate and output block store
// collects pass results, feeds the column pass and streams the output block
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module blockStore
   import idctPkg::*;
(
   input  logic      clk,
   input  logic      racc,
   input  resultWrT  resultWr,
   input  idxT       midRow,
   input  idxT       midCol,
   output midT       midOut,
   input  logic      streamEn,
   input  sampleIdxT streamIdx,
   output logic      outValid,
   output outT       dout
);

   midT       midMem [`IDCT_SAMPLES];
   outT       outMem [`IDCT_SAMPLES];
   sampleIdxT wrIdx;

   assign wrIdx = {resultWr.row, resultWr.col};

   // block memories and the stream data
   always_ff @(posedge clk)
   begin
      if (resultWr.valid)
      begin
         if (resultWr.pass == rowSel)
         begin
            midMem[wrIdx] <= midT'(resultWr.value);
         end
         else
         begin
            outMem[wrIdx] <= resultWr.value;
         end
      end
      dout <= outMem[streamIdx];
   end

   // combinational read lines up with the MAC command
   assign midOut = midMem[{midRow, midCol}];

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         outValid <= 1'b0;
      end
      else
      begin
         outValid <= streamEn;
      end
   end

   // the whole output block is final before streaming begins
   assert property (@(posedge clk) disable iff (racc) !(resultWr.valid && streamEn))
      else $error("result write during output stream");

endmodule

`default_nettype wire

// ==== design/idctPkg.sv ====
// shared types of the 8x8 inverse DCT engine
// datapath widths, sequencer states and the command and result records
`default_nettype none

`include "idct_defines.svh"

package idctPkg;

   typedef logic signed [`IDCT_SAMPLE_W-1:0] sampleT;
   typedef logic signed [`IDCT_COEF_W-1:0]   coefT;
   typedef logic signed [`IDCT_MID_W-1:0]    midT;
   typedef logic signed [`IDCT_ACC_W-1:0]    accT;
   typedef logic signed [`IDCT_OUT_W-1:0]    outT;

   // row, column or tap inside a block
   typedef logic [$clog2(`IDCT_N)-1:0]       idxT;
   // flat position inside a block
   typedef logic [$clog2(`IDCT_SAMPLES)-1:0] sampleIdxT;

   typedef enum logic [2:0] {idle, load, rowPass, colPass, stream} seqStateT;

   typedef enum logic {rowSel, colSel} passT;

   // one multiply-accumulate step
   typedef struct packed {
      logic valid;
      passT pass;
      idxT  row;
      idxT  col;
      idxT  tap;
      logic last;
   } macCmdT;

   // one finished dot product, row pass values sign-extended
   typedef struct packed {
      logic valid;
      passT pass;
      idxT  row;
      idxT  col;
      outT  value;
   } resultWrT;

endpackage

`default_nettype wire

// ==== design/idctTop.sv ====
// 8x8 inverse DCT engine top level
// loader, sequencer, shared MAC and block store in one block pipeline
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module idctTop
   import idctPkg::*;
(
   input  logic   clk,
   input  logic   racc,
   input  logic   start,
   input  sampleT din,
   output logic   reading,
   output logic   done,
   output logic   outValid,
   output outT    dout
);

   macCmdT    macCmd;
   resultWrT  resultWr;
   idxT       sampleRow;
   idxT       sampleCol;
   idxT       midRow;
   idxT       midCol;
   sampleT    sampleOut;
   midT       midOut;
   logic      streamEn;
   sampleIdxT streamIdx;

   sampleLoader u_loader (
      .clk       (clk),
      .racc      (racc),
      .reading   (reading),
      .din       (din),
      .sampleRow (sampleRow),
      .sampleCol (sampleCol),
      .sampleOut (sampleOut)
   );

   passSequencer u_seq (
      .clk       (clk),
      .racc      (racc),
      .start     (start),
      .reading   (reading),
      .done      (done),
      .macCmd    (macCmd),
      .sampleRow (sampleRow),
      .sampleCol (sampleCol),
      .midRow    (midRow),
      .midCol    (midCol),
      .streamEn  (streamEn),
      .streamIdx (streamIdx)
   );

   macUnit u_mac (
      .clk      (clk),
      .racc     (racc),
      .macCmd   (macCmd),
      .sampleIn (sampleOut),
      .midIn    (midOut),
      .resultWr (resultWr)
   );

   blockStore u_store (
      .clk       (clk),
      .racc      (racc),
      .resultWr  (resultWr),
      .midRow    (midRow),
      .midCol    (midCol),
      .midOut    (midOut),
      .streamEn  (streamEn),
      .streamIdx (streamIdx),
      .outValid  (outValid),
      .dout      (dout)
   );

endmodule

`default_nettype wire

// ==== design/idct_defines.svh ====
// 8x8 inverse DCT engine sizes
// block geometry, datapath widths and the fixed-point scaling shift
`ifndef IDCT_DEFINES_SVH
`define IDCT_DEFINES_SVH

// block geometry
`define IDCT_N        8
`define IDCT_SAMPLES  64

// input samples and Q15 cosine coefficients
`define IDCT_SAMPLE_W 16
`define IDCT_COEF_W   16

// row pass result kept between the two passes
`define IDCT_MID_W    24

// wide enough for eight exact 24x16 products
`define IDCT_ACC_W    43

// final output width
`define IDCT_OUT_W    32

// Q15 rescale after each pass
`define IDCT_SHIFT    15

`endif

// ==== design/macUnit.sv ====
// shared multiply-accumulate unit
// holds the Q15 cosine table, picks the operand of the current pass,
// registers one product per cycle and rescales each finished dot product
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module macUnit
   import idctPkg::*;
(
   input  logic     clk,
   input  logic     racc,
   input  macCmdT   macCmd,
   input  sampleT   sampleIn,
   input  midT      midIn,
   output resultWrT resultWr
);

   // coefficient (i, k) at index 8*i + k, 16-bit patterns read as signed
   localparam coefT COS_TABLE [`IDCT_SAMPLES] = '{
      16'd23170, 16'd32138, 16'd30274, 16'd27246,
      16'd23170, 16'd18205, 16'd12540, 16'd6393,
      16'd23170, 16'd27246, 16'd12540, 16'd59143,
      16'd42366, 16'd33398, 16'd35262, 16'd47331,
      16'd23170, 16'd18205, 16'd52996, 16'd33398,
      16'd42366, 16'd6393,  16'd30274, 16'd27246,
      16'd23170, 16'd6393,  16'd35262, 16'd47331,
      16'd23170, 16'd27246, 16'd52996, 16'd33398,
      16'd23170, 16'd59143, 16'd35262, 16'd18205,
      16'd23170, 16'd38290, 16'd52996, 16'd32138,
      16'd23170, 16'd47331, 16'd52996, 16'd32138,
      16'd42366, 16'd59143, 16'd30274, 16'd38290,
      16'd23170, 16'd38290, 16'd12540, 16'd6393,
      16'd42366, 16'd32138, 16'd35262, 16'd18205,
      16'd23170, 16'd33398, 16'd30274, 16'd38290,
      16'd23170, 16'd47331, 16'd12540, 16'd59143
   };

   sampleIdxT coefIdx;
   coefT      coefSel;
   midT       opA;
   accT       product;
   accT       prodReg;
   macCmdT    cmdD;
   accT       acc;
   accT       accNext;
   accT       scaled;
   outT       resValue;

   // row pass uses coef (col, tap), column pass uses coef (row, tap)
   assign coefIdx = {(macCmd.pass == rowSel) ? macCmd.col : macCmd.row, macCmd.tap};
   assign coefSel = COS_TABLE[coefIdx];
   assign opA     = (macCmd.pass == rowSel) ? midT'(sampleIn) : midIn;

   // exact signed product, sign-extended into the accumulator width
   assign product = opA * coefSel;

   always_ff @(posedge clk)
   begin
      prodReg <= product;
      if (cmdD.valid)
      begin
         acc <= accNext;
      end
   end

   // tap 0 restarts the sum
   assign accNext  = (cmdD.tap == '0) ? prodReg : acc + prodReg;
   assign scaled   = accNext >>> `IDCT_SHIFT;
   assign resValue = (cmdD.pass == rowSel) ? outT'(midT'(scaled)) : outT'(scaled);

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         cmdD     <= '0;
         resultWr <= '0;
      end
      else
      begin
         cmdD           <= macCmd;
         resultWr.valid <= cmdD.valid && cmdD.last;
         resultWr.pass  <= cmdD.pass;
         resultWr.row   <= cmdD.row;
         resultWr.col   <= cmdD.col;
         resultWr.value <= resValue;
      end
   end

   // a dot product only starts after the previous one closed or from idle
   assert property (@(posedge clk) disable iff (racc)
      (macCmd.valid && macCmd.tap == '0) |-> (!$past(macCmd.valid) || $past(macCmd.last)))
      else $error("tap 0 inside an unfinished dot product");

endmodule

`default_nettype wire

// ==== design/passSequencer.sv ====
// pass sequencer
// orders the load, the row and column passes and the output stream
// one 9-bit step counter is split into row, column and tap
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module passSequencer
   import idctPkg::*;
(
   input  logic      clk,
   input  logic      racc,
   input  logic      start,
   output logic      reading,
   output logic      done,
   output macCmdT    macCmd,
   output idxT       sampleRow,
   output idxT       sampleCol,
   output idxT       midRow,
   output idxT       midCol,
   output logic      streamEn,
   output sampleIdxT streamIdx
);

   localparam int STEP_W = $clog2(`IDCT_SAMPLES * `IDCT_N);
   localparam logic [STEP_W-1:0] LOAD_LAST  = STEP_W'(`IDCT_SAMPLES - 1);
   localparam logic [STEP_W-1:0] PASS_LAST  = STEP_W'(`IDCT_SAMPLES * `IDCT_N - 1);
   // two idle cycles let the last result reach the store
   localparam logic [STEP_W-1:0] DRAIN_LAST = STEP_W'(1);

   seqStateT          state;
   logic [STEP_W-1:0] stepCnt;
   logic              draining;
   idxT               rowIdx;
   idxT               colIdx;
   idxT               tapIdx;

   assign rowIdx = stepCnt[8:6];
   assign colIdx = stepCnt[5:3];
   assign tapIdx = stepCnt[2:0];

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         state    <= idle;
         stepCnt  <= '0;
         draining <= 1'b0;
         reading  <= 1'b0;
         done     <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            idle:
            begin
               stepCnt <= '0;
               if (start)
               begin
                  state   <= load;
                  reading <= 1'b1;
               end
            end
            load:
            begin
               stepCnt <= stepCnt + 1'b1;
               if (stepCnt == LOAD_LAST)
               begin
                  stepCnt <= '0;
                  reading <= 1'b0;
                  state   <= rowPass;
               end
            end
            rowPass, colPass:
            begin
               // counter wraps to zero at the end of the pass and times the drain
               stepCnt <= stepCnt + 1'b1;
               if (!draining)
               begin
                  if (stepCnt == PASS_LAST)
                  begin
                     draining <= 1'b1;
                  end
               end
               else if (stepCnt == DRAIN_LAST)
               begin
                  draining <= 1'b0;
                  stepCnt  <= '0;
                  if (state == rowPass)
                  begin
                     state <= colPass;
                  end
                  else
                  begin
                     state <= stream;
                     done  <= 1'b1;
                  end
               end
            end
            stream:
            begin
               stepCnt <= stepCnt + 1'b1;
               if (stepCnt == LOAD_LAST)
               begin
                  stepCnt <= '0;
                  state   <= idle;
               end
            end
            default:
            begin
               state <= idle;
            end
         endcase
      end
   end

   always_comb
   begin
      macCmd.valid = (state == rowPass || state == colPass) && !draining;
      macCmd.pass  = (state == colPass) ? colSel : rowSel;
      macCmd.row   = rowIdx;
      macCmd.col   = colIdx;
      macCmd.tap   = tapIdx;
      macCmd.last  = (tapIdx == idxT'(`IDCT_N - 1));
   end

   // row pass reads input (row, tap), column pass reads intermediate (tap, col)
   assign sampleRow = rowIdx;
   assign sampleCol = tapIdx;
   assign midRow    = tapIdx;
   assign midCol    = colIdx;

   assign streamEn  = (state == stream);
   assign streamIdx = stepCnt[5:0];

   // the MAC is never driven while loading or streaming
   assert property (@(posedge clk) disable iff (racc)
      macCmd.valid |-> !(reading || streamEn))
      else $error("MAC command issued outside the passes");

   assert property (@(posedge clk) disable iff (racc) !(done && reading))
      else $error("done raised while reading");

endmodule

`default_nettype wire

// ==== design/sampleLoader.sv ====
// input sample buffer
// captures one 8x8 block in row-major order and serves it to the row pass
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module sampleLoader
   import idctPkg::*;
(
   input  logic   clk,
   input  logic   racc,
   input  logic   reading,
   input  sampleT din,
   input  idxT    sampleRow,
   input  idxT    sampleCol,
   output sampleT sampleOut
);

   sampleT    sampleMem [`IDCT_SAMPLES];
   sampleIdxT wrCnt;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         wrCnt <= '0;
      end
      else if (reading)
      begin
         wrCnt <= wrCnt + 1'b1;
      end
   end

   // sample storage
   always_ff @(posedge clk)
   begin
      if (reading)
      begin
         sampleMem[wrCnt] <= din;
      end
   end

   assign sampleOut = sampleMem[{sampleRow, sampleCol}];

   // after a read cycle the counter is back at zero exactly when reading has dropped
   property wrapAtLastSample;
      @(posedge clk) disable iff (racc)
      $past(reading) |-> ((wrCnt == '0) == !reading);
   endproperty
   assert property (wrapAtLastSample)
      else $error("sample counter out of step with reading");

endmodule

`default_nettype wire

// ==== dv/idctTb.sv ====
// testbench for the 8x8 inverse DCT engine
// streams blocks from the data file, checks the handshake and every output
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module idctTb
   import idctPkg::*;
();

   localparam int BLOCKS           = 4;
   localparam int WORDS_PER_BLOCK  = 2 * `IDCT_SAMPLES;
   localparam int RESET_CYCLES     = 16;
   localparam int CYCLES_PER_BLOCK = 1300;
   localparam int CLK_PERIOD       = 10;
   localparam int WATCHDOG_NS      = (RESET_CYCLES + BLOCKS * CYCLES_PER_BLOCK) * CLK_PERIOD;
   // generous bound on the wait for done, the engine needs 1028 cycles
   localparam int DONE_LIMIT       = 1200;
   localparam int PASS_START_AT    = 100;
   localparam int STREAM_START_AT  = 20;
   localparam int MAX_GAP          = 20;

   logic   clk;
   logic   racc;
   logic   start;
   sampleT din;
   logic   reading;
   logic   done;
   logic   outValid;
   outT    dout;

   // per block: 64 samples, then 64 expected outputs
   logic [31:0] testData [BLOCKS * WORDS_PER_BLOCK];

   int checkCount;
   int errorCount;
   int testCount;

   idctTop u_dut (
      .clk      (clk),
      .racc     (racc),
      .start    (start),
      .din      (din),
      .reading  (reading),
      .done     (done),
      .outValid (outValid),
      .dout     (dout)
   );

   always #5 clk = ~clk;

   task automatic checkOut(input string name, input outT expected, input outT actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   // outputs are sampled and inputs driven 1 ns after the rising edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic pulseStart();
      start = 1'b1;
      nextCycle();
      start = 1'b0;
   endtask

   task automatic reportTest(input string name, input int errorsBefore);
      testCount++;
      if (errorCount == errorsBefore)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         $display("test %s: %0d errors", name, errorCount - errorsBefore);
      end
   endtask

   task automatic checkIdleAfterReset();
      int errorsBefore;
      errorsBefore = errorCount;
      repeat (4)
      begin
         checkFlag("reading", 1'b0, reading);
         checkFlag("done", 1'b0, done);
         checkFlag("outValid", 1'b0, outValid);
         nextCycle();
      end
      reportTest("reset", errorsBefore);
   endtask

   // one block: load, wait for done, then collect the stream
   task automatic runBlock(input int blk, input string name, input bit injectStart);
      int  base;
      int  errorsBefore;
      int  gap;
      int  waitCycles;
      int  n;
      outT expected;
      base         = blk * WORDS_PER_BLOCK;
      errorsBefore = errorCount;
      gap          = $urandom % (MAX_GAP + 1);
      repeat (gap) nextCycle();
      pulseStart();

      for (n = 0; n < `IDCT_SAMPLES; n++)
      begin
         checkFlag("reading", 1'b1, reading);
         din = sampleT'(testData[base + n][`IDCT_SAMPLE_W-1:0]);
         nextCycle();
      end
      checkFlag("reading", 1'b0, reading);
      din = '0;

      // start during the passes must be ignored
      waitCycles = 0;
      while (done !== 1'b1 && waitCycles < DONE_LIMIT)
      begin
         if (injectStart && waitCycles == PASS_START_AT)
         begin
            pulseStart();
         end
         else
         begin
            nextCycle();
         end
         checkFlag("reading", 1'b0, reading);
         waitCycles++;
      end

      if (done !== 1'b1)
      begin
         errorCount++;
         $display("block %s: done did not arrive within %0d cycles", name, DONE_LIMIT);
      end
      else
      begin
         checkFlag("outValid", 1'b0, outValid);
         nextCycle();
         checkFlag("done", 1'b0, done);
         for (n = 0; n < `IDCT_SAMPLES; n++)
         begin
            expected = outT'(testData[base + `IDCT_SAMPLES + n]);
            checkFlag("outValid", 1'b1, outValid);
            checkOut($sformatf("dout[%0d]", n), expected, dout);
            checkFlag("reading", 1'b0, reading);
            if (injectStart && n == STREAM_START_AT)
            begin
               pulseStart();
            end
            else
            begin
               nextCycle();
            end
         end
         checkFlag("outValid", 1'b0, outValid);
         checkFlag("reading", 1'b0, reading);
      end
      reportTest(name, errorsBefore);
   endtask

   initial
   begin
      clk        = 1'b0;
      racc       = 1'b1;
      start      = 1'b0;
      din        = '0;
      checkCount = 0;
      errorCount = 0;
      testCount  = 0;
      void'($urandom(79));
      $readmemh("dv/idct_testdata.hex", testData);

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      racc = 1'b0;

      checkIdleAfterReset();
      runBlock(0, "impulse", 1'b0);
      runBlock(1, "constant", 1'b0);
      runBlock(2, "extreme", 1'b1);
      runBlock(3, "mixed", 1'b1);

      $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/idct_testdata.hex ====
// eight 32-bit words per line, four blocks in row-major order
// each block: 8 lines of input samples (low 16 bits used), then 8 lines of expected outputs
// impulse block, single coefficient at (0,1)
00000000 00000400 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
000002C5 00000259 00000191 0000008C FFFFFF72 FFFFFE6D FFFFFDA5 FFFFFD39
// constant block, every sample 1
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001
0000001A FFFFFFF5 00000005 FFFFFFFA 00000000 FFFFFFFA 00000000 00000000
FFFFFFF8 00000002 FFFFFFFE 00000001 00000000 00000001 00000000 00000000
00000005 FFFFFFFD 00000001 FFFFFFFE 00000000 FFFFFFFE 00000000 00000000
FFFFFFFD 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000
00000003 FFFFFFFE 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 00000000
FFFFFFFF 00000000 FFFFFFFF 00000000 00000000 00000000 00000000 00000000
00000001 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 00000000
00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 00000000
// extreme block, most negative and most positive samples in row 0
FFFF8000 00000000 00000000 00000000 00000000 00000000 00000000 00007FFF
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
FFFFD1A8 FFFF8DB8 00000B41 FFFF673C 000018C4 FFFF74BF FFFFF248 FFFFAE58
// mixed block, opposite signs in column 0
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
000007D0 00000000 00000000 00000000 00000000 00000000 00000000 00000000
FFFFF448 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
FFFFFDC2 FFFFFDC2 FFFFFDC2 FFFFFDC2 FFFFFDC2 FFFFFDC2 FFFFFDC2 FFFFFDC2
0000016B 0000016B 0000016B 0000016B 0000016B 0000016B 0000016B 0000016B
0000063D 0000063D 0000063D 0000063D 0000063D 0000063D 0000063D 0000063D
000008BC 000008BC 000008BC 000008BC 000008BC 000008BC 000008BC 000008BC
00000694 00000694 00000694 00000694 00000694 00000694 00000694 00000694
0000001A 0000001A 0000001A 0000001A 0000001A 0000001A 0000001A 0000001A
FFFFF83C FFFFF83C FFFFF83C FFFFF83C FFFFF83C FFFFF83C FFFFF83C FFFFF83C
FFFFF2EC FFFFF2EC FFFFF2EC FFFFF2EC FFFFF2EC FFFFF2EC FFFFF2EC FFFFF2EC

// ==== project.f ====
+incdir+design
design/idctPkg.sv
design/sampleLoader.sv
design/passSequencer.sv
design/macUnit.sv
design/blockStore.sv
design/idctTop.sv
dv/idctTb.sv
